// File: common/gat_pkg.sv
`default_nettype none

package gat_pkg;

  // Stream and row geometry
  localparam int FEAT_W       = 8;
  localparam int NUM_FEAT_OUT = 4;
  localparam int MAX_NODES    = 8;
  localparam int NODE_IDX_W   = 4;
  localparam int IN_WORD_W    = NUM_FEAT_OUT * FEAT_W;
  localparam int OUT_FEAT_W   = 16;

  // Scoring and accumulation widths
  localparam int SCORE_W        = 20;
  localparam int WEIGHT_EXP_MAX = 7;
  localparam int WEIGHT_W       = 8;
  localparam int ACC_W          = 24;
  localparam int WSUM_W         = 12;
  localparam int LRELU_SHIFT    = 3;
  localparam int SCORE_SHIFT    = 4;

  // Attention vectors, element 0 first
  localparam logic signed [FEAT_W-1:0] A_SELF [NUM_FEAT_OUT] = '{
    8'sd3, -8'sd2, 8'sd5, 8'sd1
  };
  localparam logic signed [FEAT_W-1:0] A_NEIGH [NUM_FEAT_OUT] = '{
    8'sd2, 8'sd4, -8'sd3, 8'sd6
  };

  // Loader FSM encoding
  localparam logic [1:0] LD_HEADER = 2'd0;
  localparam logic [1:0] LD_ROWS   = 2'd1;
  localparam logic [1:0] LD_WAIT   = 2'd2;

  // Aggregator FSM encoding
  localparam logic [1:0] AG_ACC  = 2'd0;
  localparam logic [1:0] AG_LOAD = 2'd1;
  localparam logic [1:0] AG_DIV  = 2'd2;
  localparam logic [1:0] AG_OUT  = 2'd3;

  // Input word, either a subgraph header or one feature row
  typedef union packed {
    struct packed {
      logic [IN_WORD_W-NODE_IDX_W-1:0] reserved;
      logic [NODE_IDX_W-1:0]           num_nodes;
    } header;
    logic [NUM_FEAT_OUT-1:0][FEAT_W-1:0] row;
  } node_word_u;

endpackage

`default_nettype wire

// File: source/subgraph_loader.sv
`timescale 1ns/10ps
`default_nettype none

module subgraph_loader (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic [gat_pkg::IN_WORD_W-1:0]  in_data_i,
  input  logic                           in_valid_i,
  output logic                           in_ready_o,
  input  logic                           agg_done_i,
  output logic                           row_valid_o,
  output logic [gat_pkg::IN_WORD_W-1:0]  row_data_o,
  output logic [gat_pkg::NODE_IDX_W-1:0] row_idx_o,
  output logic                           row_last_o
);
  import gat_pkg::*;

  logic [1:0]            state;
  logic [NODE_IDX_W-1:0] num_nodes_q;
  logic [NODE_IDX_W-1:0] row_cnt;
  node_word_u            word;
  logic                  accept;

  assign word       = in_data_i;
  assign in_ready_o = (state != LD_WAIT);
  assign accept     = in_valid_i && in_ready_o;

  // Row side is combinational so scoring starts on the accept cycle
  assign row_valid_o = accept && (state == LD_ROWS);
  assign row_data_o  = word.row;
  assign row_idx_o   = row_cnt;
  assign row_last_o  = (row_cnt == num_nodes_q - 1'b1);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state       <= LD_HEADER;
      num_nodes_q <= '0;
      row_cnt     <= '0;
    end else begin
      case (state)
        LD_HEADER: begin
          if (accept) begin
            num_nodes_q <= word.header.num_nodes;
            row_cnt     <= '0;
            state       <= LD_ROWS;
          end
        end
        LD_ROWS: begin
          if (accept) begin
            row_cnt <= row_cnt + 1'b1;
            if (row_last_o) begin
              state <= LD_WAIT;
            end
          end
        end
        default: begin
          // Single row buffer, hold off the next subgraph
          if (agg_done_i) begin
            state <= LD_HEADER;
          end
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// File: attention/attention_score.sv
`timescale 1ns/10ps
`default_nettype none

module attention_score (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic                           row_valid_i,
  input  logic [gat_pkg::IN_WORD_W-1:0]  row_data_i,
  input  logic [gat_pkg::NODE_IDX_W-1:0] row_idx_i,
  input  logic                           row_last_i,
  output logic                           weight_valid_o,
  output logic [gat_pkg::WEIGHT_W-1:0]   weight_o,
  output logic [gat_pkg::NODE_IDX_W-1:0] weight_idx_o,
  output logic                           weight_last_o
);
  import gat_pkg::*;

  logic signed [SCORE_W-1:0] self_sum;
  logic signed [SCORE_W-1:0] neigh_sum;
  logic signed [SCORE_W-1:0] self_q;
  logic signed [SCORE_W-1:0] neigh_q;
  logic                      valid_q;
  logic [NODE_IDX_W-1:0]     idx_q;
  logic                      last_q;
  logic signed [SCORE_W-1:0] score;
  logic signed [SCORE_W-1:0] lrelu;
  logic signed [SCORE_W-1:0] scaled;
  logic signed [SCORE_W-1:0] w_exp;

  always_comb begin
    self_sum  = '0;
    neigh_sum = '0;
    for (int k = 0; k < NUM_FEAT_OUT; k++) begin
      self_sum  = self_sum + A_SELF[k] * $signed(row_data_i[k*FEAT_W +: FEAT_W]);
      neigh_sum = neigh_sum + A_NEIGH[k] * $signed(row_data_i[k*FEAT_W +: FEAT_W]);
    end
  end

  // Stage 1, self term is captured from the center row only
  always_ff @(posedge clk) begin
    if (row_valid_i && (row_idx_i == '0)) begin
      self_q <= self_sum;
    end
    neigh_q <= neigh_sum;
    idx_q   <= row_idx_i;
    last_q  <= row_last_i;
  end

  always_comb begin
    score = self_q + neigh_q;
    if (score < 0) begin
      lrelu = score >>> LRELU_SHIFT;
    end else begin
      lrelu = score;
    end
    scaled = lrelu >>> SCORE_SHIFT;
    if (scaled < 0) begin
      w_exp = '0;
    end else if (scaled > WEIGHT_EXP_MAX) begin
      w_exp = SCORE_W'(WEIGHT_EXP_MAX);
    end else begin
      w_exp = scaled;
    end
  end

  // Stage 2, power-of-two weight
  always_ff @(posedge clk) begin
    weight_o      <= WEIGHT_W'(1) << w_exp;
    weight_idx_o  <= idx_q;
    weight_last_o <= last_q;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q        <= 1'b0;
      weight_valid_o <= 1'b0;
    end else begin
      valid_q        <= row_valid_i;
      weight_valid_o <= valid_q;
    end
  end

endmodule

`default_nettype wire

// File: source/feature_buffer.sv
`timescale 1ns/10ps
`default_nettype none

module feature_buffer (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic                           wr_valid_i,
  input  logic [gat_pkg::NODE_IDX_W-1:0] wr_idx_i,
  input  logic [gat_pkg::IN_WORD_W-1:0]  wr_data_i,
  input  logic [gat_pkg::NODE_IDX_W-1:0] rd_idx_i,
  output logic [gat_pkg::IN_WORD_W-1:0]  rd_data_o
);
  import gat_pkg::*;

  logic [IN_WORD_W-1:0]             mem [MAX_NODES];
  logic [$clog2(MAX_NODES)-1:0]     wr_sel;
  logic [$clog2(MAX_NODES)-1:0]     rd_sel;

  assign wr_sel = wr_idx_i[$clog2(MAX_NODES)-1:0];
  assign rd_sel = rd_idx_i[$clog2(MAX_NODES)-1:0];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int k = 0; k < MAX_NODES; k++) begin
        mem[k] <= '0;
      end
    end else if (wr_valid_i) begin
      mem[wr_sel] <= wr_data_i;
    end
  end

  // Combinational read for the aggregator
  assign rd_data_o = mem[rd_sel];

endmodule

`default_nettype wire

// File: aggregator/aggregator.sv
`timescale 1ns/10ps
`default_nettype none

module aggregator (
  input  logic                                  clk,
  input  logic                                  rst_n,
  input  logic                                  weight_valid_i,
  input  logic [gat_pkg::WEIGHT_W-1:0]          weight_i,
  input  logic [gat_pkg::NODE_IDX_W-1:0]        weight_idx_i,
  input  logic                                  weight_last_i,
  output logic [gat_pkg::NODE_IDX_W-1:0]        rd_idx_o,
  input  logic [gat_pkg::IN_WORD_W-1:0]         rd_data_i,
  output logic                                  agg_done_o,
  output logic signed [gat_pkg::OUT_FEAT_W-1:0] out_feat_o,
  output logic                                  out_valid_o,
  output logic                                  out_last_o,
  input  logic                                  out_ready_i
);
  import gat_pkg::*;

  logic [1:0]                      state;
  logic [$clog2(NUM_FEAT_OUT)-1:0] elem;
  logic [$clog2(ACC_W)-1:0]        div_cnt;
  logic signed [ACC_W-1:0]         acc [NUM_FEAT_OUT];
  logic [WSUM_W-1:0]               wsum;
  logic signed [ACC_W-1:0]         acc_sel;
  logic [ACC_W-1:0]                rem;
  logic [ACC_W-1:0]                quo;
  logic                            neg_q;
  logic [ACC_W:0]                  shift_rem;
  logic [ACC_W:0]                  diff;
  logic signed [OUT_FEAT_W-1:0]    quo_mag;

  assign rd_idx_o = weight_idx_i;
  assign acc_sel  = acc[elem];

  // One restoring step, divisor is the weight sum
  assign shift_rem = {rem, quo[ACC_W-1]};
  assign diff      = shift_rem - {{(ACC_W + 1 - WSUM_W){1'b0}}, wsum};

  assign quo_mag     = quo[OUT_FEAT_W-1:0];
  assign out_feat_o  = neg_q ? -quo_mag : quo_mag;
  assign out_valid_o = (state == AG_OUT);
  assign out_last_o  = out_valid_o && (elem == NUM_FEAT_OUT - 1);
  assign agg_done_o  = out_last_o && out_ready_i;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state   <= AG_ACC;
      elem    <= '0;
      div_cnt <= '0;
      wsum    <= '0;
      for (int k = 0; k < NUM_FEAT_OUT; k++) begin
        acc[k] <= '0;
      end
    end else begin
      case (state)
        AG_ACC: begin
          if (weight_valid_i) begin
            for (int k = 0; k < NUM_FEAT_OUT; k++) begin
              acc[k] <= acc[k] + $signed({1'b0, weight_i})
                        * $signed(rd_data_i[k*FEAT_W +: FEAT_W]);
            end
            wsum <= wsum + WSUM_W'(weight_i);
            if (weight_last_i) begin
              state <= AG_LOAD;
            end
          end
        end
        AG_LOAD: begin
          div_cnt <= '0;
          state   <= AG_DIV;
        end
        AG_DIV: begin
          div_cnt <= div_cnt + 1'b1;
          if (div_cnt == ($clog2(ACC_W))'(ACC_W - 1)) begin
            state <= AG_OUT;
          end
        end
        default: begin
          if (out_ready_i) begin
            if (out_last_o) begin
              state <= AG_ACC;
              elem  <= '0;
              wsum  <= '0;
              for (int k = 0; k < NUM_FEAT_OUT; k++) begin
                acc[k] <= '0;
              end
            end else begin
              elem  <= elem + 1'b1;
              state <= AG_LOAD;
            end
          end
        end
      endcase
    end
  end

  // Divider datapath, magnitude in and sign kept aside
  always_ff @(posedge clk) begin
    if (state == AG_LOAD) begin
      rem   <= '0;
      quo   <= acc_sel[ACC_W-1] ? -acc_sel : acc_sel;
      neg_q <= acc_sel[ACC_W-1];
    end else if (state == AG_DIV) begin
      rem <= diff[ACC_W] ? shift_rem[ACC_W-1:0] : diff[ACC_W-1:0];
      quo <= {quo[ACC_W-2:0], ~diff[ACC_W]};
    end
  end

endmodule

`default_nettype wire

// File: source/gat_top.sv
`timescale 1ns/10ps
`default_nettype none

module gat_top (
  input  logic                                  clk,
  input  logic                                  rst_n,
  input  logic [gat_pkg::IN_WORD_W-1:0]         in_data_i,
  input  logic                                  in_valid_i,
  output logic                                  in_ready_o,
  output logic signed [gat_pkg::OUT_FEAT_W-1:0] out_feat_o,
  output logic                                  out_valid_o,
  output logic                                  out_last_o,
  input  logic                                  out_ready_i
);
  import gat_pkg::*;

  logic                   row_valid;
  logic [IN_WORD_W-1:0]   row_data;
  logic [NODE_IDX_W-1:0]  row_idx;
  logic                   row_last;
  logic                   weight_valid;
  logic [WEIGHT_W-1:0]    weight;
  logic [NODE_IDX_W-1:0]  weight_idx;
  logic                   weight_last;
  logic [NODE_IDX_W-1:0]  rd_idx;
  logic [IN_WORD_W-1:0]   rd_data;
  logic                   agg_done;

  subgraph_loader u_loader (
    .clk         (clk),
    .rst_n       (rst_n),
    .in_data_i   (in_data_i),
    .in_valid_i  (in_valid_i),
    .in_ready_o  (in_ready_o),
    .agg_done_i  (agg_done),
    .row_valid_o (row_valid),
    .row_data_o  (row_data),
    .row_idx_o   (row_idx),
    .row_last_o  (row_last)
  );

  attention_score u_score (
    .clk            (clk),
    .rst_n          (rst_n),
    .row_valid_i    (row_valid),
    .row_data_i     (row_data),
    .row_idx_i      (row_idx),
    .row_last_i     (row_last),
    .weight_valid_o (weight_valid),
    .weight_o       (weight),
    .weight_idx_o   (weight_idx),
    .weight_last_o  (weight_last)
  );

  // Rows land here in parallel with scoring
  feature_buffer u_buffer (
    .clk        (clk),
    .rst_n      (rst_n),
    .wr_valid_i (row_valid),
    .wr_idx_i   (row_idx),
    .wr_data_i  (row_data),
    .rd_idx_i   (rd_idx),
    .rd_data_o  (rd_data)
  );

  aggregator u_aggregator (
    .clk            (clk),
    .rst_n          (rst_n),
    .weight_valid_i (weight_valid),
    .weight_i       (weight),
    .weight_idx_i   (weight_idx),
    .weight_last_i  (weight_last),
    .rd_idx_o       (rd_idx),
    .rd_data_i      (rd_data),
    .agg_done_o     (agg_done),
    .out_feat_o     (out_feat_o),
    .out_valid_o    (out_valid_o),
    .out_last_o     (out_last_o),
    .out_ready_i    (out_ready_i)
  );

endmodule

`default_nettype wire

// File: verification/tb_clock_gen.sv
`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen (
  output logic clk_o,
  output logic rst_n_o
);

  // 40 ns period
  initial begin
    clk_o = 1'b0;
    forever #20 clk_o = ~clk_o;
  end

  initial begin
    rst_n_o = 1'b0;
    repeat (3) @(negedge clk_o);
    rst_n_o = 1'b1;
  end

endmodule

`default_nettype wire

// File: verification/gat_asserts.sv
`timescale 1ns/10ps
`default_nettype none

module gat_asserts (
  input logic                                  clk,
  input logic                                  rst_n,
  input logic                                  in_ready_i,
  input logic signed [gat_pkg::OUT_FEAT_W-1:0] out_feat_i,
  input logic                                  out_valid_i,
  input logic                                  out_ready_i
);

  // Output stream idle while in reset
  out_idle_in_reset: assert property (@(posedge clk) !rst_n |-> !out_valid_i)
    else $error("out_valid_o high during reset");

  out_hold_on_stall: assert property (@(posedge clk) disable iff (!rst_n)
    out_valid_i && !out_ready_i |=> out_valid_i && $stable(out_feat_i))
    else $error("output element changed while stalled");

  // Input stays closed while results drain
  in_closed_on_output: assert property (@(posedge clk) disable iff (!rst_n)
    !(in_ready_i && out_valid_i))
    else $error("in_ready_o and out_valid_o high together");

endmodule

bind gat_top gat_asserts u_asserts (
  .clk         (clk),
  .rst_n       (rst_n),
  .in_ready_i  (in_ready_o),
  .out_feat_i  (out_feat_o),
  .out_valid_i (out_valid_o),
  .out_ready_i (out_ready_i)
);

`default_nettype wire

// File: verification/gat_tb.sv
`timescale 1ns/10ps
`default_nettype none

module gat_tb;
  import gat_pkg::*;

  localparam int NAME_W    = 8 * 32;
  localparam int TAIL_WAIT = 40;

  logic                         clk;
  logic                         rst_n;
  logic [IN_WORD_W-1:0]         in_data_i;
  logic                         in_valid_i;
  logic                         in_ready_o;
  logic signed [OUT_FEAT_W-1:0] out_feat_o;
  logic                         out_valid_o;
  logic                         out_last_o;
  logic                         out_ready_i;

  logic [IN_WORD_W-1:0]         in_words [$];
  logic signed [OUT_FEAT_W-1:0] exp_feat [$];
  logic [NAME_W-1:0]            exp_name [$];

  int          data_errs;
  int          proto_errs;
  int          file_errs;
  int          timeouts;
  int          num_tests;
  int          cycle_budget;
  int          cycle_limit;
  int          cycles;
  int          word_ptr;
  int          out_cnt;
  int          tail;
  logic        finished;
  logic        in_fire;
  logic        prev_hold;
  logic [31:0] rng;
  logic signed [OUT_FEAT_W-1:0] prev_feat;

  tb_clock_gen u_clk_gen (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  gat_top DUT (
    .clk         (clk),
    .rst_n       (rst_n),
    .in_data_i   (in_data_i),
    .in_valid_i  (in_valid_i),
    .in_ready_o  (in_ready_o),
    .out_feat_o  (out_feat_o),
    .out_valid_o (out_valid_o),
    .out_last_o  (out_last_o),
    .out_ready_i (out_ready_i)
  );

  function automatic logic [31:0] next_random(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // Name, header, rows, then NUM_FEAT_OUT expected values per test
  task automatic read_vectors();
    int                fd;
    int                rc;
    int                nodes;
    logic [NAME_W-1:0] tok;
    logic [8*200-1:0]  rest;
    logic [31:0]       word;
    logic [15:0]       val;
    fd = $fopen("verification/gat_golden.txt", "r");
    if (fd == 0) begin
      $display("Cannot open verification/gat_golden.txt");
      file_errs++;
      return;
    end
    while (!$feof(fd)) begin
      rc = $fscanf(fd, "%s", tok);
      if (rc != 1) begin
        break;
      end
      if (tok == "#") begin
        rc = $fgets(rest, fd);
        continue;
      end
      rc = $fscanf(fd, "%h", word);
      nodes = int'(word[NODE_IDX_W-1:0]);
      if (rc != 1 || nodes == 0 || nodes > MAX_NODES) begin
        $display("Bad header in test %0s", tok);
        file_errs++;
        break;
      end
      in_words.push_back(word);
      for (int i = 0; i < nodes; i++) begin
        rc = $fscanf(fd, "%h", word);
        in_words.push_back(word);
      end
      for (int k = 0; k < NUM_FEAT_OUT; k++) begin
        rc = $fscanf(fd, "%h", val);
        exp_feat.push_back(val);
        exp_name.push_back(tok);
      end
      cycle_budget += nodes + 1 + NUM_FEAT_OUT * (ACC_W + 2);
      num_tests++;
    end
    $fclose(fd);
    if (num_tests == 0) begin
      $display("No tests found in the vector file");
      file_errs++;
    end
  endtask

  task automatic check_output();
    logic want_last;
    if (out_cnt >= exp_feat.size()) begin
      $display("Extra output %0d after all expected values", out_feat_o);
      proto_errs++;
      return;
    end
    if (out_feat_o !== exp_feat[out_cnt]) begin
      $display("ERR %0s element %0d: expected %0d, got %0d", exp_name[out_cnt],
               out_cnt % NUM_FEAT_OUT, exp_feat[out_cnt], out_feat_o);
      data_errs++;
    end
    want_last = ((out_cnt % NUM_FEAT_OUT) == NUM_FEAT_OUT - 1);
    if (out_last_o !== want_last) begin
      if (want_last) begin
        $display("Missing out_last_o on the final element of %0s", exp_name[out_cnt]);
      end else begin
        $display("out_last_o raised early on element %0d of %0s",
                 out_cnt % NUM_FEAT_OUT, exp_name[out_cnt]);
      end
      proto_errs++;
    end
    out_cnt++;
  endtask

  initial begin
    in_data_i   = '0;
    in_valid_i  = 1'b0;
    out_ready_i = 1'b0;
    rng         = 32'd5806;
    read_vectors();
    cycle_limit = 4 * cycle_budget + 100;
    while (rst_n !== 1'b1) begin
      @(negedge clk);
      if (out_valid_o !== 1'b0 || in_ready_o !== 1'b1) begin
        $display("Wrong output state during reset");
        proto_errs++;
      end
    end
    finished  = (file_errs != 0);
    in_fire   = 1'b0;
    prev_hold = 1'b0;
    prev_feat = '0;
    while (!finished && cycles < cycle_limit) begin
      @(negedge clk);
      cycles++;
      if (in_fire) begin
        word_ptr++;
      end
      if (word_ptr < in_words.size()) begin
        in_valid_i = 1'b1;
        in_data_i  = in_words[word_ptr];
      end else begin
        in_valid_i = 1'b0;
        in_data_i  = '0;
      end
      in_fire = in_valid_i && in_ready_o;
      if (prev_hold && (out_valid_o !== 1'b1 || out_feat_o !== prev_feat)) begin
        $display("Output element dropped or changed while out_ready_i was low");
        proto_errs++;
      end
      if (in_ready_o && out_valid_o) begin
        $display("Input accepted while results are still pending");
        proto_errs++;
      end
      rng         = next_random(rng);
      out_ready_i = (rng[1:0] != 2'b00);
      if (out_valid_o && out_ready_i) begin
        check_output();
      end
      prev_hold = out_valid_o && !out_ready_i;
      prev_feat = out_feat_o;
      // Run on a little to catch outputs beyond the last test
      if (word_ptr >= in_words.size() && out_cnt >= exp_feat.size()) begin
        tail++;
        finished = (tail >= TAIL_WAIT);
      end
    end
    if (!finished) begin
      $display("Timeout after %0d cycles, %0d of %0d outputs seen",
               cycles, out_cnt, exp_feat.size());
      timeouts++;
    end
    $display("Tests %0d, data errors %0d, protocol errors %0d, file errors %0d, timeouts %0d",
             num_tests, data_errs, proto_errs, file_errs, timeouts);
    if (data_errs + proto_errs + file_errs + timeouts == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: verification/gat_golden.txt
# Per test: name, header word, one word per row (feature 0 in the low byte),
# then the four expected outputs as 16-bit two's complement, all in hex
single_node
  00000001 fb1eec0a
  000a ffec 001e fffb

single_node_extremes
  00000001 00ff7f80
  ff80 007f ffff 0000

two_node_mean
  00000002 01020004 02000301
  0001 0002 0000 0001

leaky_and_clamp
  00000003 0506fc0a 14fd02f6 f11ef6ec
  fffa 0000 ffff 0010

full_eight_nodes
  00000008 01010101 0a000000 00000a00 000a0000
  00000005 fd000000 14001400 000000f9
  0000 0010 0000 0011

negative_truncation
  00000002 000000ce 0000f8f7
  ffe3 fffc 0000 0000

four_node_mix
  00000004 00050a14 0000009c 05f60000 fd03fd03
  0009 0004 fffe 0002

repeat_two_node
  00000002 01020004 02000301
  0001 0002 0000 0001

repeat_single_node
  00000001 fb1eec0a
  000a ffec 001e fffb

// File: vlog.f
common/gat_pkg.sv
source/subgraph_loader.sv
attention/attention_score.sv
source/feature_buffer.sv
aggregator/aggregator.sv
source/gat_top.sv
verification/tb_clock_gen.sv
verification/gat_asserts.sv
verification/gat_tb.sv

// File: Makefile
OBJ_DIR = obj_dir
LOG     = sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f vlog.f \
		--top-module gat_tb -Mdir $(OBJ_DIR) -o gat_sim

run: compile
	./$(OBJ_DIR)/gat_sim | tee $(LOG)
	grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
